//--- include/aon_params.svh
////////////////////
// widths, counts and pad indices for the always-on pad block
////////////////////

`ifndef AON_PARAMS_SVH
`define AON_PARAMS_SVH

// vector widths
`define AON_GPIO_W 32
`define AON_MIO_N 22
`define AON_RAMP_W 4
`define AON_SETTLE_W 3

// settle window in clk_aon cycles
`define AON_SETTLE_CYCLES 6

// fake supply pattern thresholds on the ramp count
`define AON_SUPP_ON0 4
`define AON_SUPP_OFF 8
`define AON_SUPP_ON1 12

// core pad indices
`define AON_GEN_N 14
`define AON_STRAP_N 3
`define AON_MIO_SW_STRAP 14
`define AON_MIO_TAP0 17
`define AON_MIO_TAP1 18
`define AON_MIO_UART_RX 19
`define AON_MIO_UART_TX 20
`define AON_MIO_USB_SENSE 21

// pad vector positions
`define AON_GPIO_SW_STRAP 22
`define AON_GPIO_TAP0 27
`define AON_GPIO_TAP1 30

`endif

//--- src/aon_pkg.sv
////////////////////
// pad vector and counter types
// power-on sequencer state encoding
////////////////////

`include "aon_params.svh"

package aon_pkg;

  ////////////////////
  // pad mapping, core pad to pad vector
  ////////////////////
  // mio 0..13   -> gpio 0..13   generic gpio
  // mio 14..16  -> gpio 22..24  software straps
  // mio 17      -> gpio 27      tap strap
  // mio 18      -> gpio 30      tap strap
  // mio 19      <- uart_rx_i    input only
  // mio 20      -> uart_tx_o    output only
  // mio 21      <- usb_sense_i  input only
  // every other gpio output bit is tied to zero

  // full pad side gpio vector
  typedef logic [`AON_GPIO_W-1:0] gpio_vec_t;

  // core multiplexed pad vector
  typedef logic [`AON_MIO_N-1:0] mio_vec_t;

  // saturating supply ramp
  typedef logic [`AON_RAMP_W-1:0] ramp_cnt_t;

  // settle window count
  typedef logic [`AON_SETTLE_W-1:0] settle_cnt_t;

  // power-on sequencer states
  typedef enum logic [1:0] {
    POR_OFF    = 2'd0,
    POR_SETTLE = 2'd1,
    POR_ON     = 2'd2
  } por_state_t;

endpackage

//--- src/supply_timer_if.sv
////////////////////
// supply and settle timer link
////////////////////

`timescale 1ns/1ps

interface supply_timer_if;

  // timer to sequencer
  logic vcc_supp;
  logic settle_done;

  // sequencer to timer
  logic settle_clear;
  logic settle_run;

  modport timer (
    output vcc_supp,
    output settle_done,
    input  settle_clear,
    input  settle_run
  );

  modport sequencer (
    input  vcc_supp,
    input  settle_done,
    output settle_clear,
    output settle_run
  );

endinterface

//--- src/supply_timer.sv
////////////////////
// fake supply ramp and settle window counter
////////////////////

`timescale 1ns/1ps

`include "aon_params.svh"

module supply_timer (
  input logic          clk_aon,
  input logic          rst_n_i,
  supply_timer_if.timer tmr
);

  aon_pkg::ramp_cnt_t   ramp_cnt_q;
  aon_pkg::settle_cnt_t settle_cnt_q;

  ////////////////////
  // supply ramp
  ////////////////////

  // counts up once per cycle and sticks at all ones
  always_ff @(posedge clk_aon) begin
    if (!rst_n_i) begin
      ramp_cnt_q <= '0;
    end else if (ramp_cnt_q != '1) begin
      ramp_cnt_q <= ramp_cnt_q + 1'b1;
    end
  end

  // low, short high glitch, low, then high for good
  always_comb begin
    if (ramp_cnt_q < aon_pkg::ramp_cnt_t'(`AON_SUPP_ON0)) begin
      tmr.vcc_supp = 1'b0;
    end else if (ramp_cnt_q < aon_pkg::ramp_cnt_t'(`AON_SUPP_OFF)) begin
      tmr.vcc_supp = 1'b1;
    end else if (ramp_cnt_q < aon_pkg::ramp_cnt_t'(`AON_SUPP_ON1)) begin
      tmr.vcc_supp = 1'b0;
    end else begin
      tmr.vcc_supp = 1'b1;
    end
  end

  ////////////////////
  // settle window
  ////////////////////

  // clear wins over run, count saturates at the window length
  always_ff @(posedge clk_aon) begin
    if (!rst_n_i || tmr.settle_clear) begin
      settle_cnt_q <= '0;
    end else if (tmr.settle_run && !tmr.settle_done) begin
      settle_cnt_q <= settle_cnt_q + 1'b1;
    end
  end

  assign tmr.settle_done = (settle_cnt_q == aon_pkg::settle_cnt_t'(`AON_SETTLE_CYCLES));

endmodule

//--- src/por_sequencer.sv
////////////////////
// power-ok sequencer FSM
// drives the pad clamp
////////////////////

`timescale 1ns/1ps

module por_sequencer (
  input  logic              clk_aon,
  input  logic              rst_n_i,
  supply_timer_if.sequencer seq,
  output logic              clamp_o,
  output logic              por_ok_o
);

  aon_pkg::por_state_t state_q;
  aon_pkg::por_state_t state_d;
  logic                por_ok_q;
  logic                clamp_q;

  ////////////////////
  // next state
  ////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      aon_pkg::POR_OFF: begin
        if (seq.vcc_supp) begin
          state_d = aon_pkg::POR_SETTLE;
        end
      end
      aon_pkg::POR_SETTLE: begin
        // any supply drop restarts the window
        if (!seq.vcc_supp) begin
          state_d = aon_pkg::POR_OFF;
        end else if (seq.settle_done) begin
          state_d = aon_pkg::POR_ON;
        end
      end
      // supply never falls again once on
      aon_pkg::POR_ON: state_d = aon_pkg::POR_ON;
      default: state_d = aon_pkg::POR_OFF;
    endcase
  end

  // settle count sits at zero while off, so each entry starts clean
  assign seq.settle_clear = (state_q == aon_pkg::POR_OFF);
  assign seq.settle_run   = (state_q == aon_pkg::POR_SETTLE);

  ////////////////////
  // state and outputs
  ////////////////////

  always_ff @(posedge clk_aon) begin
    if (!rst_n_i) begin
      state_q  <= aon_pkg::POR_OFF;
      por_ok_q <= 1'b0;
      clamp_q  <= 1'b1;
    end else begin
      state_q  <= state_d;
      // power-ok tracks the state it is entering
      por_ok_q <= (state_d == aon_pkg::POR_ON);
      clamp_q  <= (state_d != aon_pkg::POR_ON);
    end
  end

  assign por_ok_o = por_ok_q;
  assign clamp_o  = clamp_q;

endmodule

//--- src/pad_bridge.sv
////////////////////
// core pad to gpio vector bridge
// registered, clamped to zero while power is not ok
////////////////////

`timescale 1ns/1ps

`include "aon_params.svh"

module pad_bridge (
  input  logic              clk_aon,
  input  logic              rst_n_i,
  input  logic              clamp_i,
  input  aon_pkg::gpio_vec_t gpio_p2d_i,
  input  logic              uart_rx_i,
  input  logic              usb_sense_i,
  input  aon_pkg::mio_vec_t  mio_out_i,
  input  aon_pkg::mio_vec_t  mio_oe_i,
  input  aon_pkg::mio_vec_t  mio_pull_en_i,
  input  aon_pkg::mio_vec_t  mio_pull_sel_i,
  output aon_pkg::mio_vec_t  mio_in_o,
  output aon_pkg::gpio_vec_t gpio_d2p_o,
  output aon_pkg::gpio_vec_t gpio_en_o,
  output aon_pkg::gpio_vec_t gpio_pull_en_o,
  output aon_pkg::gpio_vec_t gpio_pull_sel_o,
  output logic              uart_tx_o,
  output logic              uart_tx_en_o
);

  aon_pkg::mio_vec_t mio_in_d;

  ////////////////////
  // mapping
  ////////////////////

  // same bit placement for data, enable and both pull attributes
  function automatic aon_pkg::gpio_vec_t scatter(input aon_pkg::mio_vec_t mio);
    aon_pkg::gpio_vec_t gpio;
    gpio = '0;
    gpio[`AON_GEN_N-1:0] = mio[`AON_GEN_N-1:0];
    gpio[`AON_GPIO_SW_STRAP +: `AON_STRAP_N] = mio[`AON_MIO_SW_STRAP +: `AON_STRAP_N];
    gpio[`AON_GPIO_TAP0] = mio[`AON_MIO_TAP0];
    gpio[`AON_GPIO_TAP1] = mio[`AON_MIO_TAP1];
    return gpio;
  endfunction

  // pad inputs back to core pads, uart tx slot reads as zero
  always_comb begin
    mio_in_d = '0;
    mio_in_d[`AON_GEN_N-1:0] = gpio_p2d_i[`AON_GEN_N-1:0];
    mio_in_d[`AON_MIO_SW_STRAP +: `AON_STRAP_N] = gpio_p2d_i[`AON_GPIO_SW_STRAP +: `AON_STRAP_N];
    mio_in_d[`AON_MIO_TAP0] = gpio_p2d_i[`AON_GPIO_TAP0];
    mio_in_d[`AON_MIO_TAP1] = gpio_p2d_i[`AON_GPIO_TAP1];
    mio_in_d[`AON_MIO_UART_RX] = uart_rx_i;
    mio_in_d[`AON_MIO_USB_SENSE] = usb_sense_i;
  end

  ////////////////////
  // output registers
  ////////////////////

  // clamp acts like a held reset on both directions
  always_ff @(posedge clk_aon) begin
    if (!rst_n_i || clamp_i) begin
      mio_in_o        <= '0;
      gpio_d2p_o      <= '0;
      gpio_en_o       <= '0;
      gpio_pull_en_o  <= '0;
      gpio_pull_sel_o <= '0;
      uart_tx_o       <= 1'b0;
      uart_tx_en_o    <= 1'b0;
    end else begin
      mio_in_o        <= mio_in_d;
      gpio_d2p_o      <= scatter(mio_out_i);
      gpio_en_o       <= scatter(mio_oe_i);
      gpio_pull_en_o  <= scatter(mio_pull_en_i);
      gpio_pull_sel_o <= scatter(mio_pull_sel_i);
      // uart tx has its own pins
      uart_tx_o       <= mio_out_i[`AON_MIO_UART_TX];
      uart_tx_en_o    <= mio_oe_i[`AON_MIO_UART_TX];
    end
  end

endmodule

//--- src/aon_pad_top.sv
////////////////////
// always-on pad top
// power-on sequence plus pad bridge
////////////////////

`timescale 1ns/1ps

module aon_pad_top (
  input  logic              clk_aon,
  input  logic              rst_n_i,
  // pad side inputs
  input  aon_pkg::gpio_vec_t gpio_p2d_i,
  input  logic              uart_rx_i,
  input  logic              usb_sense_i,
  // core side pad controls
  input  aon_pkg::mio_vec_t  mio_out_i,
  input  aon_pkg::mio_vec_t  mio_oe_i,
  input  aon_pkg::mio_vec_t  mio_pull_en_i,
  input  aon_pkg::mio_vec_t  mio_pull_sel_i,
  output aon_pkg::mio_vec_t  mio_in_o,
  // pad side outputs
  output aon_pkg::gpio_vec_t gpio_d2p_o,
  output aon_pkg::gpio_vec_t gpio_en_o,
  output aon_pkg::gpio_vec_t gpio_pull_en_o,
  output aon_pkg::gpio_vec_t gpio_pull_sel_o,
  output logic              uart_tx_o,
  output logic              uart_tx_en_o,
  output logic              por_ok_o
);

  logic clamp;

  supply_timer_if u_tmr_if ();

  supply_timer u_supply_timer (
    .clk_aon (clk_aon),
    .rst_n_i (rst_n_i),
    .tmr     (u_tmr_if.timer)
  );

  por_sequencer u_por_seq (
    .clk_aon  (clk_aon),
    .rst_n_i  (rst_n_i),
    .seq      (u_tmr_if.sequencer),
    .clamp_o  (clamp),
    .por_ok_o (por_ok_o)
  );

  pad_bridge u_pad_bridge (
    .clk_aon         (clk_aon),
    .rst_n_i         (rst_n_i),
    .clamp_i         (clamp),
    .gpio_p2d_i      (gpio_p2d_i),
    .uart_rx_i       (uart_rx_i),
    .usb_sense_i     (usb_sense_i),
    .mio_out_i       (mio_out_i),
    .mio_oe_i        (mio_oe_i),
    .mio_pull_en_i   (mio_pull_en_i),
    .mio_pull_sel_i  (mio_pull_sel_i),
    .mio_in_o        (mio_in_o),
    .gpio_d2p_o      (gpio_d2p_o),
    .gpio_en_o       (gpio_en_o),
    .gpio_pull_en_o  (gpio_pull_en_o),
    .gpio_pull_sel_o (gpio_pull_sel_o),
    .uart_tx_o       (uart_tx_o),
    .uart_tx_en_o    (uart_tx_en_o)
  );

endmodule

//--- test/aon_pad_properties.sv
////////////////////
// power-ok and clamp assertions
////////////////////

`timescale 1ns/1ps

module aon_pad_properties #(
  parameter bit SEQ_SIDE = 1'b1
) (
  input logic               clk_aon,
  input logic               rst_n_i,
  input logic               clamp_i,
  input logic               por_ok_i,
  input aon_pkg::gpio_vec_t en_i,
  input logic               tx_en_i
);

  if (SEQ_SIDE) begin : g_seq
    // clamp is always the inverse of power-ok
    clamp_inverse: assert property (@(posedge clk_aon) disable iff (!rst_n_i)
      clamp_i == !por_ok_i)
      else $error("clamp does not track power-ok");

    // power-ok is sticky
    por_ok_sticky: assert property (@(posedge clk_aon) disable iff (!rst_n_i)
      por_ok_i |=> por_ok_i)
      else $error("power-ok fell outside reset");
  end else begin : g_pad
    // no pad may be driven while clamped
    clamp_no_enable: assert property (@(posedge clk_aon) disable iff (!rst_n_i)
      clamp_i |-> (en_i == '0 && !tx_en_i))
      else $error("pad enable high while clamped");
  end

endmodule

bind por_sequencer aon_pad_properties #(.SEQ_SIDE(1'b1)) u_seq_props (
  .clk_aon (clk_aon), .rst_n_i (rst_n_i), .clamp_i (clamp_o),
  .por_ok_i (por_ok_o), .en_i ('0), .tx_en_i (1'b0)
);

bind pad_bridge aon_pad_properties #(.SEQ_SIDE(1'b0)) u_pad_props (
  .clk_aon (clk_aon), .rst_n_i (rst_n_i), .clamp_i (clamp_i),
  .por_ok_i (!clamp_i), .en_i (gpio_en_o), .tx_en_i (uart_tx_en_o)
);

//--- test/aon_pad_tb.sv
////////////////////
// testbench for the always-on pad top
// file driven vectors, random vectors, power-on checks
////////////////////

`timescale 1ns/1ps

`include "aon_params.svh"

module aon_pad_tb;

  localparam int POR_TIMEOUT = 100;
  localparam int POR_MAX = 12 + `AON_SETTLE_CYCLES + 3;

  logic               clk_aon;
  logic               rst_n_i;
  aon_pkg::gpio_vec_t gpio_p2d_i;
  logic               uart_rx_i;
  logic               usb_sense_i;
  aon_pkg::mio_vec_t  mio_out_i;
  aon_pkg::mio_vec_t  mio_oe_i;
  aon_pkg::mio_vec_t  mio_pull_en_i;
  aon_pkg::mio_vec_t  mio_pull_sel_i;
  aon_pkg::mio_vec_t  mio_in_o;
  aon_pkg::gpio_vec_t gpio_d2p_o;
  aon_pkg::gpio_vec_t gpio_en_o;
  aon_pkg::gpio_vec_t gpio_pull_en_o;
  aon_pkg::gpio_vec_t gpio_pull_sel_o;
  logic               uart_tx_o;
  logic               uart_tx_en_o;
  logic               por_ok_o;

  int errors;
  int other_errors;
  integer seed;

  aon_pad_top DUT (.*);

  initial begin
    clk_aon = 1'b0;
    forever #10 clk_aon = ~clk_aon;
  end

  task automatic check_value(input string test, input string field,
                             input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      errors++;
      $display("mismatch %s %s expected %h actual %h", test, field, exp, act);
    end
  endtask

  // every output the core or the pads can see must read zero
  task automatic check_clamped(input string test);
    check_value(test, "por_ok", 32'd0, {31'd0, por_ok_o});
    check_value(test, "gpio_d2p", 32'd0, gpio_d2p_o);
    check_value(test, "gpio_en", 32'd0, gpio_en_o);
    check_value(test, "gpio_pull_en", 32'd0, gpio_pull_en_o);
    check_value(test, "gpio_pull_sel", 32'd0, gpio_pull_sel_o);
    check_value(test, "mio_in", 32'd0, {10'd0, mio_in_o});
    check_value(test, "uart_tx", 32'd0, {30'd0, uart_tx_o, uart_tx_en_o});
  endtask

  ////////////////////
  // reference mapping from the pad table
  ////////////////////

  function automatic aon_pkg::gpio_vec_t map_to_pads(input aon_pkg::mio_vec_t m);
    aon_pkg::gpio_vec_t g;
    g = '0;
    for (int i = 0; i < 14; i++) begin
      g[i] = m[i];
    end
    for (int i = 0; i < 3; i++) begin
      g[22 + i] = m[14 + i];
    end
    g[27] = m[17];
    g[30] = m[18];
    return g;
  endfunction

  function automatic aon_pkg::mio_vec_t gather_from_pads(input aon_pkg::gpio_vec_t g,
                                                         input logic rx, input logic usb);
    aon_pkg::mio_vec_t m;
    m = '0;
    for (int i = 0; i < 14; i++) begin
      m[i] = g[i];
    end
    for (int i = 0; i < 3; i++) begin
      m[14 + i] = g[22 + i];
    end
    m[17] = g[27];
    m[18] = g[30];
    m[19] = rx;
    m[21] = usb;
    return m;
  endfunction

  // drive one vector, then compare one cycle later
  task automatic apply_vector(input string test, input logic [31:0] f[14]);
    @(posedge clk_aon);
    gpio_p2d_i     <= f[0];
    uart_rx_i      <= f[1][0];
    usb_sense_i    <= f[2][0];
    mio_out_i      <= f[3][21:0];
    mio_oe_i       <= f[4][21:0];
    mio_pull_en_i  <= f[5][21:0];
    mio_pull_sel_i <= f[6][21:0];
    @(posedge clk_aon);
    @(negedge clk_aon);
    check_value(test, "por_ok", 32'd1, {31'd0, por_ok_o});
    check_value(test, "gpio_d2p", f[7], gpio_d2p_o);
    check_value(test, "gpio_en", f[8], gpio_en_o);
    check_value(test, "gpio_pull_en", f[9], gpio_pull_en_o);
    check_value(test, "gpio_pull_sel", f[10], gpio_pull_sel_o);
    check_value(test, "mio_in", f[11], {10'd0, mio_in_o});
    check_value(test, "uart_tx", f[12], {31'd0, uart_tx_o});
    check_value(test, "uart_tx_en", f[13], {31'd0, uart_tx_en_o});
  endtask

  initial begin
    int n;
    int fd;
    int cnt;
    bit por_seen;
    string line;
    string name;
    logic [31:0] f[14];

    errors = 0;
    other_errors = 0;
    seed = 83;
    rst_n_i = 1'b0;
    gpio_p2d_i = '0;
    uart_rx_i = 1'b0;
    usb_sense_i = 1'b0;
    mio_out_i = '0;
    mio_oe_i = '0;
    mio_pull_en_i = '0;
    mio_pull_sel_i = '0;

    // reset with every input high
    repeat (4) begin
      @(posedge clk_aon);
      gpio_p2d_i     <= '1;
      uart_rx_i      <= 1'b1;
      usb_sense_i    <= 1'b1;
      mio_out_i      <= '1;
      mio_oe_i       <= '1;
      mio_pull_en_i  <= '1;
      mio_pull_sel_i <= '1;
      @(negedge clk_aon);
      check_clamped("reset");
    end
    @(posedge clk_aon);
    rst_n_i <= 1'b1;

    ////////////////////
    // power-on, glitch must not pass
    ////////////////////
    n = 0;
    por_seen = 1'b0;
    while (!por_seen && n < POR_TIMEOUT) begin
      @(posedge clk_aon);
      n++;
      @(negedge clk_aon);
      if (por_ok_o) begin
        por_seen = 1'b1;
      end else begin
        check_clamped("por_wait");
      end
    end
    if (!por_seen) begin
      other_errors++;
      $display("timeout: power-ok did not rise within %0d cycles", POR_TIMEOUT);
    end else if (n < 12 || n > POR_MAX) begin
      other_errors++;
      $display("power-ok rose %0d cycles after reset, outside 12 to %0d", n, POR_MAX);
    end

    ////////////////////
    // vectors from file
    ////////////////////
    fd = $fopen("test/pad_input.dat", "r");
    if (fd == 0) begin
      other_errors++;
      $display("could not open the stimulus file test/pad_input.dat");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line[0] != "#") begin
          cnt = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h", name,
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                        f[9], f[10], f[11], f[12], f[13]);
          if (cnt != 15) begin
            other_errors++;
            $display("stimulus line could not be read: %s", line);
          end else begin
            apply_vector(name, f);
          end
        end
      end
      $fclose(fd);
    end

    // random filler vectors against the table
    for (int k = 0; k < 20; k++) begin
      f[0] = $random(seed);
      f[1] = {31'd0, 1'($random(seed))};
      f[2] = {31'd0, 1'($random(seed))};
      for (int j = 3; j < 7; j++) begin
        f[j] = {10'd0, 22'($random(seed))};
      end
      for (int j = 0; j < 4; j++) begin
        f[7 + j] = map_to_pads(f[3 + j][21:0]);
      end
      f[11] = {10'd0, gather_from_pads(f[0], f[1][0], f[2][0])};
      f[12] = {31'd0, f[3][20]};
      f[13] = {31'd0, f[4][20]};
      apply_vector("random", f);
    end

    $display("summary: %0d mismatches, %0d other errors", errors, other_errors);
    if (errors == 0 && other_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- test/pad_input.dat
# name p2d uart_rx usb_sense out oe pull_en pull_sel
#   exp: d2p en pull_en pull_sel mio_in uart_tx uart_tx_en (all hex)
gen_bit0 00000000 0 0 000001 000001 000000 000000 00000001 00000001 00000000 00000000 000000 0 0
gen_all 00000000 0 0 003fff 003fff 000000 000000 00003fff 00003fff 00000000 00000000 000000 0 0
gen_data_only 00000000 0 0 002aaa 000000 000000 000000 00002aaa 00000000 00000000 00000000 000000 0 0
sw_strap 00000000 0 0 01c000 01c000 000000 000000 01c00000 01c00000 00000000 00000000 000000 0 0
tap_strap 00000000 0 0 060000 060000 000000 000000 48000000 48000000 00000000 00000000 000000 0 0
pull_map 00000000 0 0 000000 000000 3fffff 040001 00000000 00000000 49c03fff 40000001 000000 0 0
uart_tx 00000000 0 0 100000 100000 000000 000000 00000000 00000000 00000000 00000000 000000 1 1
core_all 00000000 0 0 3fffff 3fffff 000000 000000 49c03fff 49c03fff 00000000 00000000 000000 1 1
pads_all ffffffff 1 1 000000 000000 000000 000000 00000000 00000000 00000000 00000000 2fffff 0 0
strap_in 49c00000 0 0 000000 000000 000000 000000 00000000 00000000 00000000 00000000 07c000 0 0
unused_in b63fc000 0 0 000000 000000 000000 000000 00000000 00000000 00000000 00000000 000000 0 0
uart_rx 00000000 1 0 000000 000000 000000 000000 00000000 00000000 00000000 00000000 080000 0 0
usb_sense 00000000 0 1 000000 000000 000000 000000 00000000 00000000 00000000 00000000 200000 0 0

//--- tb.f
+incdir+include
src/aon_pkg.sv
src/supply_timer_if.sv
src/supply_timer.sv
src/por_sequencer.sv
src/pad_bridge.sv
src/aon_pad_top.sv
test/aon_pad_properties.sv
test/aon_pad_tb.sv

//--- run.sh
#!/bin/bash
# build and run the testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f tb.f --top-module aon_pad_tb \
  -Mdir obj_dir -o simv &&
./obj_dir/simv > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qxF '** PASS **' sim.log && echo "simulation passed" || {
  echo "simulation failed"
  exit 1
}
